//--- axi/axi_burst_engine.sv
// AXI4 burst engine, one packet in flight
`timescale 1ns/1ns

module axi_burst_engine
  (input  logic                                  core_clk_i
   , input  logic                                rst_n_i

   , input  dma_axi_pkg::dma_pkt_s               pkt_i
   , input  logic                                pkt_v_i
   , output logic                                pkt_ready_and_o
   , output logic                                read_accept_o

   , output dma_axi_pkg::axi_ax_s                aw_o
   , output logic                                awvalid_o
   , input  logic                                awready_i

   , input  dma_axi_pkg::axi_w_s                 w_beat_i
   , input  logic                                w_beat_v_i
   , output logic                                beat_taken_o
   , output dma_axi_pkg::axi_w_s                 w_o
   , output logic                                wvalid_o
   , input  logic                                wready_i

   , input  logic [dma_axi_pkg::axi_resp_w-1:0]  bresp_i
   , input  logic                                bvalid_i
   , output logic                                bready_o

   , output dma_axi_pkg::axi_ax_s                ar_o
   , output logic                                arvalid_o
   , input  logic                                arready_i

   , input  dma_axi_pkg::axi_r_s                 r_i
   , input  logic                                rvalid_i
   , output logic                                rready_o
   , input  logic                                sipo_full_i
   , output logic                                r_write_o
   );

  import dma_axi_pkg::*;

  engine_state_e state_q;
  engine_state_e state_n;
  dma_pkt_s      pkt_q;
  axi_ax_s       ax;
  logic          pkt_accept;

  assign pkt_ready_and_o = (state_q == e_idle);
  assign pkt_accept      = pkt_v_i & pkt_ready_and_o;
  assign read_accept_o   = pkt_accept & ~pkt_i.write_not_read;

  always_ff @(posedge core_clk_i)
  begin
    if (pkt_accept)
      pkt_q <= pkt_i;
  end

  // Fixed four beat INCR burst at the block address
  assign ax.addr  = pkt_q.addr;
  assign ax.len   = burst_len_c;
  assign ax.size  = size_c;
  assign ax.burst = burst_incr_c;
  assign aw_o     = ax;
  assign ar_o     = ax;

  assign awvalid_o = (state_q == e_aw);
  assign arvalid_o = (state_q == e_ar);

  assign w_o          = w_beat_i;
  assign wvalid_o     = (state_q == e_w) & w_beat_v_i;
  assign beat_taken_o = wvalid_o & wready_i;

  assign bready_o = (state_q == e_b);

  // No room in the collector means no R beat
  assign rready_o  = (state_q == e_r) & ~sipo_full_i;
  assign r_write_o = rvalid_i & rready_o;

  always_comb
  begin
    state_n = state_q;
    unique case (state_q)
      e_idle:
        if (pkt_accept)
          state_n = pkt_i.write_not_read ? e_aw : e_ar;
      e_aw:
        if (awready_i)
          state_n = e_w;
      e_w:
        if (beat_taken_o && w_beat_i.last)
          state_n = e_b;
      e_b:
        if (bvalid_i)
          state_n = e_idle;
      e_ar:
        if (arready_i)
          state_n = e_r;
      e_r:
        if (r_write_o && r_i.last)
          state_n = e_idle;
      default:
        state_n = e_idle;
    endcase
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      state_q <= e_idle;
    else
      state_q <= state_n;
  end

endmodule

//--- common/dma_axi_pkg.sv
// DMA to AXI bridge shared definitions

package dma_axi_pkg;

  // Bus and fill geometry
  localparam int addr_w     = 32;
  localparam int axi_data_w = 32;
  localparam int fill_w     = 128;
  localparam int beats_c    = fill_w / axi_data_w;
  localparam int beat_cnt_w = 2;
  localparam int strb_w     = axi_data_w / 8;

  // Emulated read latency setting
  localparam int lat_w = 16;

  // AXI4 field widths
  localparam int axi_len_w   = 8;
  localparam int axi_size_w  = 3;
  localparam int axi_burst_w = 2;
  localparam int axi_resp_w  = 2;

  // One burst covers exactly one fill
  localparam logic [axi_len_w-1:0]   burst_len_c  = axi_len_w'(beats_c - 1);
  localparam logic [axi_size_w-1:0]  size_c       = 3'b010;
  localparam logic [axi_burst_w-1:0] burst_incr_c = 2'b01;

  typedef struct packed
  {
    logic              write_not_read;
    logic [addr_w-1:0] addr;
  } dma_pkt_s;

  // Shared by AW and AR
  typedef struct packed
  {
    logic [addr_w-1:0]      addr;
    logic [axi_len_w-1:0]   len;
    logic [axi_size_w-1:0]  size;
    logic [axi_burst_w-1:0] burst;
  } axi_ax_s;

  typedef struct packed
  {
    logic [axi_data_w-1:0] data;
    logic [strb_w-1:0]     strb;
    logic                  last;
  } axi_w_s;

  typedef struct packed
  {
    logic [axi_data_w-1:0] data;
    logic [axi_resp_w-1:0] resp;
    logic                  last;
  } axi_r_s;

  typedef enum logic [2:0]
  {
    e_idle,
    e_aw,
    e_w,
    e_b,
    e_ar,
    e_r
  } engine_state_e;

endpackage

//--- list.f
common/dma_axi_pkg.sv
logic/reset_sync.sv
logic/beat_serializer.sv
logic/beat_deserializer.sv
logic/latency_gate.sv
axi/axi_burst_engine.sv
logic/dma_axi_top.sv
tb/dma_axi_properties.sv
tb/tb_dma_axi.sv

//--- logic/beat_deserializer.sv
// AXI read beat to fill collector
`timescale 1ns/1ns

module beat_deserializer
  (input  logic                              core_clk_i
   , input  logic                            rst_n_i
   , input  dma_axi_pkg::axi_r_s             beat_i
   , input  logic                            beat_write_i
   , output logic                            full_o
   , output logic [dma_axi_pkg::fill_w-1:0]  fill_o
   , input  logic                            release_i
   , output logic                            fill_v_o
   , input  logic                            fill_ready_and_i
   );

  import dma_axi_pkg::*;

  logic [beats_c-1:0][axi_data_w-1:0] words_q;
  logic [beat_cnt_w-1:0]              cnt_q;
  logic                               full_q;

  assign full_o   = full_q;
  assign fill_o   = words_q;
  // Held back until the latency gate lets it through
  assign fill_v_o = full_q & release_i;

  always_ff @(posedge core_clk_i)
  begin
    if (beat_write_i)
      words_q[cnt_q] <= beat_i.data;
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      full_q <= 1'b0;
      cnt_q  <= '0;
    end
    else if (beat_write_i)
    begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == beat_cnt_w'(beats_c - 1))
        full_q <= 1'b1;
    end
    else if (fill_v_o && fill_ready_and_i)
      full_q <= 1'b0;
  end

endmodule

//--- logic/beat_serializer.sv
// Write fill to AXI beat splitter
`timescale 1ns/1ns

module beat_serializer
  (input  logic                              core_clk_i
   , input  logic                            rst_n_i
   , input  logic [dma_axi_pkg::fill_w-1:0]  fill_i
   , input  logic                            fill_v_i
   , output logic                            fill_ready_and_o
   , output dma_axi_pkg::axi_w_s             beat_o
   , output logic                            beat_v_o
   , input  logic                            beat_taken_i
   );

  import dma_axi_pkg::*;

  logic [beats_c-1:0][axi_data_w-1:0] words_q;
  logic [beat_cnt_w-1:0]              cnt_q;
  logic                               full_q;
  logic                               last_beat;
  logic                               fill_take;

  assign fill_ready_and_o = ~full_q;
  assign fill_take        = fill_v_i & fill_ready_and_o;
  assign last_beat        = (cnt_q == beat_cnt_w'(beats_c - 1));

  // Low word goes out first
  assign beat_o.data = words_q[cnt_q];
  assign beat_o.strb = '1;
  assign beat_o.last = last_beat;
  assign beat_v_o    = full_q;

  always_ff @(posedge core_clk_i)
  begin
    if (fill_take)
      words_q <= fill_i;
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      full_q <= 1'b0;
      cnt_q  <= '0;
    end
    else if (fill_take)
    begin
      full_q <= 1'b1;
      cnt_q  <= '0;
    end
    else if (beat_taken_i)
    begin
      cnt_q <= cnt_q + 1'b1;
      if (last_beat)
        full_q <= 1'b0;
    end
  end

endmodule

//--- logic/dma_axi_top.sv
// DMA to AXI4 bridge top level
`timescale 1ns/1ns

module dma_axi_top
  (input  logic                                  core_clk_i
   , input  logic                                arst_n_i

   , input  dma_axi_pkg::dma_pkt_s               dma_pkt_i
   , input  logic                                dma_pkt_v_i
   , output logic                                dma_pkt_ready_and_o

   , input  logic [dma_axi_pkg::fill_w-1:0]      dma_data_i
   , input  logic                                dma_data_v_i
   , output logic                                dma_data_ready_and_o

   , output logic [dma_axi_pkg::fill_w-1:0]      dma_data_o
   , output logic                                dma_data_v_o
   , input  logic                                dma_data_ready_and_i

   , input  logic                                cdl_en_i
   , input  logic [dma_axi_pkg::lat_w-1:0]       cdl_lat_i
   , output logic                                cdl_gate_o

   , output dma_axi_pkg::axi_ax_s                m_axi_aw_o
   , output logic                                m_axi_awvalid_o
   , input  logic                                m_axi_awready_i

   , output dma_axi_pkg::axi_w_s                 m_axi_w_o
   , output logic                                m_axi_wvalid_o
   , input  logic                                m_axi_wready_i

   , input  logic [dma_axi_pkg::axi_resp_w-1:0]  m_axi_bresp_i
   , input  logic                                m_axi_bvalid_i
   , output logic                                m_axi_bready_o

   , output dma_axi_pkg::axi_ax_s                m_axi_ar_o
   , output logic                                m_axi_arvalid_o
   , input  logic                                m_axi_arready_i

   , input  dma_axi_pkg::axi_r_s                 m_axi_r_i
   , input  logic                                m_axi_rvalid_i
   , output logic                                m_axi_rready_o
   );

  import dma_axi_pkg::*;

  logic   rst_n;
  axi_w_s ser_beat;
  logic   ser_beat_v;
  logic   beat_taken;
  logic   des_full;
  logic   r_write;
  logic   read_accept;
  logic   gate_release;

  reset_sync core_rst
    (.core_clk_i(core_clk_i)
     ,.arst_n_i(arst_n_i)
     ,.rst_n_o(rst_n)
     );

  beat_serializer wr_piso
    (.core_clk_i(core_clk_i)
     ,.rst_n_i(rst_n)
     ,.fill_i(dma_data_i)
     ,.fill_v_i(dma_data_v_i)
     ,.fill_ready_and_o(dma_data_ready_and_o)
     ,.beat_o(ser_beat)
     ,.beat_v_o(ser_beat_v)
     ,.beat_taken_i(beat_taken)
     );

  beat_deserializer rd_sipo
    (.core_clk_i(core_clk_i)
     ,.rst_n_i(rst_n)
     ,.beat_i(m_axi_r_i)
     ,.beat_write_i(r_write)
     ,.full_o(des_full)
     ,.fill_o(dma_data_o)
     ,.release_i(gate_release)
     ,.fill_v_o(dma_data_v_o)
     ,.fill_ready_and_i(dma_data_ready_and_i)
     );

  latency_gate cdl
    (.core_clk_i(core_clk_i)
     ,.rst_n_i(rst_n)
     ,.en_i(cdl_en_i)
     ,.lat_i(cdl_lat_i)
     ,.read_accept_i(read_accept)
     ,.fill_done_i(des_full)
     ,.release_o(gate_release)
     ,.gate_o(cdl_gate_o)
     );

  axi_burst_engine engine
    (.core_clk_i(core_clk_i)
     ,.rst_n_i(rst_n)
     ,.pkt_i(dma_pkt_i)
     ,.pkt_v_i(dma_pkt_v_i)
     ,.pkt_ready_and_o(dma_pkt_ready_and_o)
     ,.read_accept_o(read_accept)
     ,.aw_o(m_axi_aw_o)
     ,.awvalid_o(m_axi_awvalid_o)
     ,.awready_i(m_axi_awready_i)
     ,.w_beat_i(ser_beat)
     ,.w_beat_v_i(ser_beat_v)
     ,.beat_taken_o(beat_taken)
     ,.w_o(m_axi_w_o)
     ,.wvalid_o(m_axi_wvalid_o)
     ,.wready_i(m_axi_wready_i)
     ,.bresp_i(m_axi_bresp_i)
     ,.bvalid_i(m_axi_bvalid_i)
     ,.bready_o(m_axi_bready_o)
     ,.ar_o(m_axi_ar_o)
     ,.arvalid_o(m_axi_arvalid_o)
     ,.arready_i(m_axi_arready_i)
     ,.r_i(m_axi_r_i)
     ,.rvalid_i(m_axi_rvalid_i)
     ,.rready_o(m_axi_rready_o)
     ,.sipo_full_i(des_full)
     ,.r_write_o(r_write)
     );

endmodule

//--- logic/latency_gate.sv
// Emulated read latency and core stall gate
`timescale 1ns/1ns

module latency_gate
  (input  logic                             core_clk_i
   , input  logic                           rst_n_i
   , input  logic                           en_i
   , input  logic [dma_axi_pkg::lat_w-1:0]  lat_i
   , input  logic                           read_accept_i
   , input  logic                           fill_done_i
   , output logic                           release_o
   , output logic                           gate_o
   );

  import dma_axi_pkg::*;

  logic [lat_w-1:0] cnt_q;
  logic             pending_q;
  logic             hold_q;
  logic             expired;

  assign expired = (cnt_q == '0);

  // A fill already shown stays shown when the next read loads the counter
  assign release_o = ~en_i | expired | hold_q;

  // Core would be stalled on memory here
  assign gate_o = en_i & expired & pending_q & ~fill_done_i;

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt_q     <= '0;
      pending_q <= 1'b0;
      hold_q    <= 1'b0;
    end
    else
    begin
      hold_q <= fill_done_i & release_o;
      if (read_accept_i)
      begin
        cnt_q     <= lat_i;
        pending_q <= 1'b1;
      end
      else
      begin
        if (!expired)
          cnt_q <= cnt_q - 1'b1;
        // An old fill still on display belongs to the previous read
        if (fill_done_i && !hold_q)
          pending_q <= 1'b0;
      end
    end
  end

endmodule

//--- logic/reset_sync.sv
// Core reset synchronizer
`timescale 1ns/1ns

module reset_sync
  (input  logic   core_clk_i
   , input  logic arst_n_i
   , output logic rst_n_o
   );

  logic [1:0] sync_q;

  // Assert at once, release after two edges
  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      sync_q <= '0;
    else
      sync_q <= {sync_q[0], 1'b1};
  end

  assign rst_n_o = sync_q[1];

endmodule

//--- run.sh
#!/bin/sh
# Build and run the DMA bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_dma_axi \
  -Mdir obj_dir -o sim_dma_axi
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_dma_axi > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  exit 0
else
  exit 1
fi

//--- tb/dma_axi_properties.sv
// AXI and stall gate checks
`timescale 1ns/1ns

module dma_axi_properties
  (input  logic   clk_i
   , input  logic rst_n_i
   , input  logic awvalid_i
   , input  logic awready_i
   , input  logic wvalid_i
   , input  logic wready_i
   , input  logic wlast_i
   , input  logic arvalid_i
   , input  logic arready_i
   , input  logic cdl_en_i
   , input  logic cdl_gate_i
   );

  logic [1:0] wcnt_q;

  // Beat position inside the current W burst
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      wcnt_q <= '0;
    else if (wvalid_i && wready_i)
      wcnt_q <= wlast_i ? 2'd0 : wcnt_q + 2'd1;
  end

  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    awvalid_i && !awready_i |=> awvalid_i)
    else $error("awvalid dropped before awready");

  w_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wvalid_i && !wready_i |=> wvalid_i)
    else $error("wvalid dropped before wready");

  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    arvalid_i && !arready_i |=> arvalid_i)
    else $error("arvalid dropped before arready");

  wlast_pos: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wvalid_i |-> (wlast_i == (wcnt_q == 2'd3)))
    else $error("wlast not on the fourth beat");

  gate_off: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !cdl_en_i |-> !cdl_gate_i)
    else $error("cdl_gate_o high while disabled");

endmodule

//--- tb/tb_dma_axi.sv
// DMA to AXI bridge testbench
`timescale 1ns/1ns

module tb_dma_axi;

  import dma_axi_pkg::*;

  localparam int period_c    = 100;
  localparam int txn_c       = 20;
  localparam int worst_txn_c = 160;

  logic                  clk;
  logic                  arst_n;
  dma_pkt_s              pkt;
  logic                  pkt_v;
  logic                  pkt_rdy;
  logic [fill_w-1:0]     wfill;
  logic                  wfill_v;
  logic                  wfill_rdy;
  logic [fill_w-1:0]     rfill;
  logic                  rfill_v;
  logic                  rfill_rdy;
  logic                  cdl_en;
  logic [lat_w-1:0]      cdl_lat;
  logic                  cdl_gate;
  axi_ax_s               aw;
  logic                  awvalid;
  logic                  awready;
  axi_w_s                w;
  logic                  wvalid;
  logic                  wready;
  logic [axi_resp_w-1:0] bresp;
  logic                  bvalid;
  logic                  bready;
  axi_ax_s               ar;
  logic                  arvalid;
  logic                  arready;
  axi_r_s                r;
  logic                  rvalid;
  logic                  rready;

  logic [15:0]           lfsr_q = 16'd58;
  logic [31:0]           mem[logic [31:0]];
  logic [31:0]           ref_mem[logic [31:0]];
  logic [fill_w-1:0]     exp_q[$];
  logic [fill_w-1:0]     exp_fill;
  logic [addr_w-1:0]     cur_addr;
  logic [fill_w-1:0]     cur_fill;
  logic                  slow_mem;
  int                    cycle = 0;
  int                    gate_cnt = 0;
  int                    accept_cycle;
  int                    errors = 0;
  int                    tests_run = 0;
  int                    tests_failed = 0;

  dma_axi_top uut
    (.core_clk_i(clk)
     ,.arst_n_i(arst_n)
     ,.dma_pkt_i(pkt)
     ,.dma_pkt_v_i(pkt_v)
     ,.dma_pkt_ready_and_o(pkt_rdy)
     ,.dma_data_i(wfill)
     ,.dma_data_v_i(wfill_v)
     ,.dma_data_ready_and_o(wfill_rdy)
     ,.dma_data_o(rfill)
     ,.dma_data_v_o(rfill_v)
     ,.dma_data_ready_and_i(rfill_rdy)
     ,.cdl_en_i(cdl_en)
     ,.cdl_lat_i(cdl_lat)
     ,.cdl_gate_o(cdl_gate)
     ,.m_axi_aw_o(aw)
     ,.m_axi_awvalid_o(awvalid)
     ,.m_axi_awready_i(awready)
     ,.m_axi_w_o(w)
     ,.m_axi_wvalid_o(wvalid)
     ,.m_axi_wready_i(wready)
     ,.m_axi_bresp_i(bresp)
     ,.m_axi_bvalid_i(bvalid)
     ,.m_axi_bready_o(bready)
     ,.m_axi_ar_o(ar)
     ,.m_axi_arvalid_o(arvalid)
     ,.m_axi_arready_i(arready)
     ,.m_axi_r_i(r)
     ,.m_axi_rvalid_i(rvalid)
     ,.m_axi_rready_o(rready)
     );

  bind dma_axi_top dma_axi_properties props
    (.clk_i(core_clk_i)
     ,.rst_n_i(rst_n)
     ,.awvalid_i(m_axi_awvalid_o)
     ,.awready_i(m_axi_awready_i)
     ,.wvalid_i(m_axi_wvalid_o)
     ,.wready_i(m_axi_wready_i)
     ,.wlast_i(m_axi_w_o.last)
     ,.arvalid_i(m_axi_arvalid_o)
     ,.arready_i(m_axi_arready_i)
     ,.cdl_en_i(cdl_en_i)
     ,.cdl_gate_i(cdl_gate_o)
     );

  initial
  begin
    clk = 1'b0;
    forever #(period_c / 2) clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cdl_gate)
      gate_cnt <= gate_cnt + 1;
  end

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Unwritten words read as address XOR A5A5A5A5
  function automatic logic [fill_w-1:0] expected_fill(input logic [addr_w-1:0] addr);
    logic [fill_w-1:0] f;
    logic [addr_w-1:0] a;
    f = '0;
    for (int k = 0; k < 4; k++)
    begin
      a = addr + 32'(4 * k);
      f[k*32 +: 32] = ref_mem.exists(a) ? ref_mem[a] : (a ^ 32'hA5A5A5A5);
    end
    return f;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return mem.exists(a) ? mem[a] : (a ^ 32'hA5A5A5A5);
  endfunction

  task automatic value_error(input string name, input logic [fill_w-1:0] got,
                             input logic [fill_w-1:0] exp);
    errors++;
    $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
  endtask

  task automatic fail_note(input string what);
    errors++;
    $display("at %0t ns: %s", $time, what);
  endtask

  task automatic expect_low(input string name, input logic v);
    if (v !== 1'b0)
      value_error(name, fill_w'(v), '0);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before)
      $display("test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  task automatic mem_wait();
    int n;
    n = int'(rand_bits(2)) + (slow_mem ? 6 : 0);
    @(negedge clk);
    repeat (n) @(negedge clk);
  endtask

  task automatic serve_write();
    axi_ax_s a;
    axi_w_s  wb;
    mem_wait();
    awready = 1'b1;
    @(posedge clk);
    a = aw;
    @(negedge clk);
    awready = 1'b0;
    if (a.addr !== cur_addr)
      value_error("m_axi_aw_o.addr", fill_w'(a.addr), fill_w'(cur_addr));
    if (a.len !== 8'd3)
      value_error("m_axi_aw_o.len", fill_w'(a.len), fill_w'(3));
    if (a.size !== 3'd2)
      value_error("m_axi_aw_o.size", fill_w'(a.size), fill_w'(2));
    if (a.burst !== 2'd1)
      value_error("m_axi_aw_o.burst", fill_w'(a.burst), fill_w'(1));
    for (int k = 0; k < 4; k++)
    begin
      mem_wait();
      wready = 1'b1;
      @(posedge clk);
      while (!wvalid) @(posedge clk);
      wb = w;
      @(negedge clk);
      wready = 1'b0;
      if (wb.strb !== 4'hF)
        value_error("m_axi_w_o.strb", fill_w'(wb.strb), fill_w'(4'hF));
      if (wb.last !== (k == 3))
        value_error("m_axi_w_o.last", fill_w'(wb.last), fill_w'(k == 3));
      if (wb.data !== cur_fill[k*32 +: 32])
        value_error("m_axi_w_o.data", fill_w'(wb.data), fill_w'(cur_fill[k*32 +: 32]));
      mem[a.addr + 32'(4 * k)] = wb.data;
    end
    mem_wait();
    bvalid = 1'b1;
    @(posedge clk);
    while (!bready) @(posedge clk);
    @(negedge clk);
    bvalid = 1'b0;
  endtask

  task automatic serve_read();
    axi_ax_s a;
    mem_wait();
    arready = 1'b1;
    @(posedge clk);
    a = ar;
    @(negedge clk);
    arready = 1'b0;
    if (a.len !== 8'd3)
      value_error("m_axi_ar_o.len", fill_w'(a.len), fill_w'(3));
    if (a.size !== 3'd2)
      value_error("m_axi_ar_o.size", fill_w'(a.size), fill_w'(2));
    if (a.burst !== 2'd1)
      value_error("m_axi_ar_o.burst", fill_w'(a.burst), fill_w'(1));
    for (int k = 0; k < 4; k++)
    begin
      mem_wait();
      r.data = mem_word(a.addr + 32'(4 * k));
      r.resp = '0;
      r.last = (k == 3);
      rvalid = 1'b1;
      @(posedge clk);
      while (!rready) @(posedge clk);
      @(negedge clk);
      rvalid = 1'b0;
    end
  endtask

  // AXI memory model
  initial
  begin
    awready = 1'b0;
    wready  = 1'b0;
    bresp   = '0;
    bvalid  = 1'b0;
    arready = 1'b0;
    r       = '0;
    rvalid  = 1'b0;
    forever
    begin
      @(posedge clk);
      if (awvalid)
        serve_write();
      else if (arvalid)
        serve_read();
    end
  end

  // Delivered fills against the reference
  always @(posedge clk)
  begin
    if (rfill_v && rfill_rdy)
    begin
      if (exp_q.size() == 0)
        fail_note("a fill was delivered with no read outstanding");
      else
      begin
        exp_fill = exp_q.pop_front();
        if (rfill !== exp_fill)
          value_error("dma_data_o", rfill, exp_fill);
      end
    end
  end

  task automatic send_pkt(input logic wnr, input logic [addr_w-1:0] addr);
    @(negedge clk);
    pkt.write_not_read = wnr;
    pkt.addr = addr;
    pkt_v = 1'b1;
    @(posedge clk);
    while (!pkt_rdy) @(posedge clk);
    accept_cycle = cycle;
    @(negedge clk);
    pkt_v = 1'b0;
  endtask

  task automatic do_write(input logic [addr_w-1:0] addr, input logic [fill_w-1:0] fill);
    cur_addr = addr;
    cur_fill = fill;
    @(negedge clk);
    wfill = fill;
    wfill_v = 1'b1;
    @(posedge clk);
    while (!wfill_rdy) @(posedge clk);
    @(negedge clk);
    wfill_v = 1'b0;
    send_pkt(1'b1, addr);
    @(posedge clk);
    while (!(bvalid && bready)) @(posedge clk);
    for (int k = 0; k < 4; k++)
      ref_mem[addr + 32'(4 * k)] = fill[k*32 +: 32];
  endtask

  task automatic do_read(input logic [addr_w-1:0] addr);
    exp_q.push_back(expected_fill(addr));
    send_pkt(1'b0, addr);
  endtask

  // Queue is popped on the rising edge, so look on the falling one
  task automatic wait_drained();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic wait_fill_valid();
    @(posedge clk);
    while (!rfill_v) @(posedge clk);
  endtask

  initial
  begin
    int                e0;
    int                g0;
    int                t0;
    int                idx;
    logic [addr_w-1:0] blocks [8];
    logic [fill_w-1:0] held;
    arst_n    = 1'b0;
    pkt       = '0;
    pkt_v     = 1'b0;
    wfill     = '0;
    wfill_v   = 1'b0;
    rfill_rdy = 1'b1;
    cdl_en    = 1'b0;
    cdl_lat   = '0;
    slow_mem  = 1'b0;
    blocks = '{32'h100, 32'h200, 32'h340, 32'h1000, 32'h0, 32'h7F0, 32'hABC0, 32'hFFF0};
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    repeat (3) @(negedge clk);

    e0 = errors;
    expect_low("m_axi_awvalid_o", awvalid);
    expect_low("m_axi_wvalid_o", wvalid);
    expect_low("m_axi_bready_o", bready);
    expect_low("m_axi_arvalid_o", arvalid);
    expect_low("m_axi_rready_o", rready);
    expect_low("dma_data_v_o", rfill_v);
    expect_low("cdl_gate_o", cdl_gate);
    // Idle engine and empty splitter both accept
    if (pkt_rdy !== 1'b1)
      value_error("dma_pkt_ready_and_o", fill_w'(pkt_rdy), fill_w'(1));
    if (wfill_rdy !== 1'b1)
      value_error("dma_data_ready_and_o", fill_w'(wfill_rdy), fill_w'(1));
    finish_test("reset state", e0);

    e0 = errors;
    for (int i = 0; i < 3; i++)
      do_write(blocks[i], {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)});
    finish_test("write bursts", e0);

    e0 = errors;
    for (int i = 0; i < 8; i++)
    begin
      idx = int'(rand_bits(3));
      do_read(blocks[idx]);
    end
    wait_drained();
    finish_test("random reads", e0);

    // Long latency holds the fill back
    e0 = errors;
    cdl_en  = 1'b1;
    cdl_lat = 16'd40;
    do_read(blocks[0]);
    t0 = accept_cycle;
    wait_fill_valid();
    if (cycle - t0 < 40)
      fail_note($sformatf("fill shown %0d cycles after accept, latency is 40", cycle - t0));
    wait_drained();
    finish_test("latency hold", e0);

    e0 = errors;
    cdl_lat  = 16'd2;
    slow_mem = 1'b1;
    g0 = gate_cnt;
    do_read(blocks[3]);
    wait_drained();
    if (gate_cnt == g0)
      fail_note("cdl_gate_o never rose with a slow memory");
    finish_test("stall gate", e0);

    e0 = errors;
    cdl_en = 1'b0;
    g0 = gate_cnt;
    do_read(blocks[1]);
    do_read(blocks[4]);
    wait_drained();
    slow_mem = 1'b0;
    if (gate_cnt != g0)
      fail_note("cdl_gate_o rose with the gate disabled");
    finish_test("gate disabled", e0);

    // Core back-pressure on the read fill
    e0 = errors;
    rfill_rdy = 1'b0;
    do_read(blocks[1]);
    wait_fill_valid();
    held = rfill;
    do_read(blocks[2]);
    repeat (20)
    begin
      @(posedge clk);
      if (!rfill_v)
        fail_note("dma_data_v_o dropped while the core held ready low");
      if (rfill !== held)
        value_error("dma_data_o", rfill, held);
      if (rready)
        fail_note("an R beat was accepted while the fill was still held");
    end
    @(negedge clk);
    rfill_rdy = 1'b1;
    wait_drained();
    finish_test("core back-pressure", e0);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial
  begin
    #(longint'(txn_c) * worst_txn_c * period_c);
    $display("timeout: the tests did not finish in time");
    $display("tests failed");
    $finish;
  end

endmodule
